//--- eq_trace.txt
# W addr data (hex), S sample (hex, left high), X expected output (hex)
# I idle cycles (decimal), T starts a named test
T bypass
S 12345678
X 12345678
S ffff0001
X ffff0001
T limiter
W 2d 003e8
W 3d 00001
S 1388ec78
X 03e8fc18
S ec781388
X fc1803e8
S 012c012c
X 012c012c
T eq_identity
W 0f 04000
W 14 04000
W 19 04000
W 1e 04000
W 23 04000
W 13 00000
I 10
W 3e 00010
S 1388ec78
X 1388ec78
S 00000000
X 00000000
T eq_feedback
W 0f 02000
W 12 3e000
W 13 00000
I 10
S 0fa0f060
X 07d0f830
S 00000000
X 03e8fc18
S 00000000
X 01f4fe0c
S 00000000
X 00faff06
S 00000000
X 007dff83
S 00000000
X 003effc1
T saturation
W 0f 10000
W 12 00000
W 13 00000
I 10
S 4e20b1e0
X 7fff8000
S 03e8fc18
X 0fa0f060
T atomic_update
W 14 08000
S 03e8fc18
X 0fa0f060
W 18 00000
I 10
S 03e8fc18
X 1f40e0c0

//--- list.f
audio_eq_pkg.sv
eq_coeff_loader.sv
eq_band.sv
effect_output.sv
audio_eq_top.sv
tb_audio_eq.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_audio_eq
FILELIST  = list.f
BUILD_DIR = obj_dir

SIM     = $(BUILD_DIR)/V$(TOP)
SOURCES = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; \
	echo "$$out" | grep -q '^Verification passed$$'

clean:
	rm -rf $(BUILD_DIR)

//--- tb_audio_eq.sv
module tb_audio_eq
    import audio_eq_pkg::*;
();

    logic      clk;
    logic      reset_n;
    logic      cfg_write;
    cfg_addr_t cfg_addr;
    cfg_data_t cfg_data;
    logic      in_valid;
    stereo_t   in_sample;
    logic      out_valid;
    stereo_t   out_sample;

    stereo_t   exp_q [$];                     // expected outputs, oldest first
    int        issue_q [$];                   // cycle each sample was driven
    logic      eq_on       = 1'b0;            // equalizer enable as last written
    int        check_cnt   = 0;
    int        error_cnt   = 0;
    int        test_cnt    = 0;
    int        cycle_cnt   = 0;
    int        cycle_limit = 0;               // set once the trace is counted
    string     test_name   = "";
    int        test_checks = 0;               // totals when the test started
    int        test_errors = 0;

    audio_eq_top u_audio_eq_top (
        .clk        (clk),
        .reset_n    (reset_n),
        .cfg_write  (cfg_write),
        .cfg_addr   (cfg_addr),
        .cfg_data   (cfg_data),
        .in_valid   (in_valid),
        .in_sample  (in_sample),
        .out_valid  (out_valid),
        .out_sample (out_sample)
    );

    always #20 clk = ~clk;                    // 40 unit period

    ////////////////////////////////////////////////////////////////////////////
    // stimulus helpers, inputs change 2 units after the rising edge

    task automatic next_edge();
        @(posedge clk);
        #2;
    endtask

    task automatic write_reg(input cfg_addr_t addr, input cfg_data_t data);
        next_edge();
        cfg_write = 1'b1;
        cfg_addr  = addr;
        cfg_data  = data;
        in_valid  = 1'b0;
        if (addr == EFFECT_EN2_ADDR) begin
            eq_on = data[EQ_EN_BIT];          // selects 6 or 1 cycle latency
        end
    endtask

    task automatic drive_sample(input stereo_t s);
        next_edge();
        cfg_write = 1'b0;
        in_valid  = 1'b1;
        in_sample = s;
        issue_q.push_back(cycle_cnt);
    endtask

    task automatic idle_cycle();
        next_edge();
        cfg_write = 1'b0;
        in_valid  = 1'b0;
    endtask

    task automatic check_fields(input int got, input int want, input string line);
        if (got != want) begin
            $display("trace line has %0d fields instead of %0d: %s", got, want, line);
            error_cnt++;
        end
    endtask

    // wait for the pipeline to empty, then report the open test
    task automatic close_test();
        if (test_name.len() > 0) begin
            idle_cycle();
            while (exp_q.size() > 0) begin
                idle_cycle();
            end
            repeat (8) idle_cycle();          // catches stray outputs too
            test_cnt++;
            $display("test %s: %0d checks, %0d errors", test_name,
                     check_cnt - test_checks, error_cnt - test_errors);
        end
    endtask

    function automatic string strip_eol(input string s);
        string r;
        r = s;
        while (r.len() > 0 && (r.getc(r.len() - 1) == "\n" ||
                               r.getc(r.len() - 1) == "\r" ||
                               r.getc(r.len() - 1) == " ")) begin
            r = r.substr(0, r.len() - 2);
        end
        return r;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // output checker, sampled mid cycle

    always @(negedge clk) begin
        stereo_t expected;
        int      issued;
        int      exp_lat;
        if (reset_n && out_valid) begin
            if (exp_q.size() == 0) begin
                $display("output %08h at %0t arrived with no expected value left",
                         out_sample, $time);
                error_cnt++;
            end else begin
                expected = exp_q.pop_front();
                exp_lat  = eq_on ? 6 : 1;     // five bands plus the output stage
                if (issue_q.size() > 0) begin
                    issued = issue_q.pop_front();
                end else begin
                    issued = -1;
                end
                check_cnt++;
                assert (out_sample == expected) else begin
                    $display("** Error at %0t: out_sample expected %08h, actual %08h",
                             $time, expected, out_sample);
                    error_cnt++;
                end
                assert (cycle_cnt - issued == exp_lat) else begin
                    $display("** Error at %0t: out_valid latency expected %0d, actual %0d",
                             $time, exp_lat, cycle_cnt - issued);
                    error_cnt++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected outputs never arrived",
                     cycle_limit, exp_q.size());
            $display("Verification failed");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // trace replay

    initial begin
        int          fd;
        int          n_lines;
        int          code;
        string       line;
        byte         op;
        logic [31:0] a_val;
        logic [31:0] d_val;
        int          n_idle;

        clk       = 1'b0;
        reset_n   = 1'b0;
        cfg_write = 1'b0;
        cfg_addr  = '0;
        cfg_data  = '0;
        in_valid  = 1'b0;
        in_sample = '0;
        n_lines   = 0;

        fd = $fopen("eq_trace.txt", "r");
        if (fd == 0) begin
            $display("cannot open the trace file eq_trace.txt");
            $display("Verification failed");
            $finish;
        end else begin
            while ($fgets(line, fd) > 0) begin
                n_lines++;
            end
            $fclose(fd);
            cycle_limit = 20 * n_lines + 200;
            fd = $fopen("eq_trace.txt", "r");

            repeat (4) @(posedge clk);
            #2;
            reset_n = 1'b1;

            while ($fgets(line, fd) > 0) begin
                line = strip_eol(line);
                if (line.len() == 0 || line.getc(0) == "#") begin
                    continue;
                end
                op = line.getc(0);
                case (op)
                    "W": begin
                        code = $sscanf(line, "%c %h %h", op, a_val, d_val);
                        check_fields(code, 3, line);
                        write_reg(a_val[5:0], d_val[17:0]);
                    end
                    "S": begin
                        code = $sscanf(line, "%c %h", op, d_val);
                        check_fields(code, 2, line);
                        drive_sample(d_val);
                    end
                    "X": begin
                        code = $sscanf(line, "%c %h", op, d_val);
                        check_fields(code, 2, line);
                        exp_q.push_back(d_val);
                    end
                    "I": begin
                        code = $sscanf(line, "%c %d", op, n_idle);
                        check_fields(code, 2, line);
                        repeat (n_idle) idle_cycle();
                    end
                    "T": begin
                        close_test();
                        test_name   = line.substr(2, line.len() - 1);
                        test_checks = check_cnt;
                        test_errors = error_cnt;
                    end
                    default: begin
                        $display("unknown trace line: %s", line);
                        error_cnt++;
                    end
                endcase
            end
            close_test();
            $fclose(fd);

            $display("tests %0d, checks %0d, errors %0d", test_cnt, check_cnt, error_cnt);
            if (error_cnt == 0 && check_cnt > 0) begin
                $display("Verification passed");
            end else begin
                $display("Verification failed");
            end
            $finish;
        end
    end

endmodule

//--- audio_eq_top.sv
module audio_eq_top
    import audio_eq_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       cfg_write,
    input  cfg_addr_t  cfg_addr,
    input  cfg_data_t  cfg_data,
    input  logic       in_valid,
    input  stereo_t    in_sample,
    output logic       out_valid,
    output stereo_t    out_sample
);

    logic    coeff_shift;
    logic    coeff_commit;
    coef_t   coeff_word  [NUM_BANDS];

    // index n is the input of band n, the last index is the cascade output
    logic    band_valid  [NUM_BANDS + 1];
    stereo_t band_sample [NUM_BANDS + 1];

    assign band_valid[0]  = in_valid;
    assign band_sample[0] = in_sample;

    ////////////////////////////////////////////////////////////////////////////
    // coefficient loader

    eq_coeff_loader u_loader (
        .clk          (clk),
        .reset_n      (reset_n),
        .cfg_write    (cfg_write),
        .cfg_addr     (cfg_addr),
        .cfg_data     (cfg_data),
        .coeff_shift  (coeff_shift),
        .coeff_word   (coeff_word),
        .coeff_commit (coeff_commit)
    );

    ////////////////////////////////////////////////////////////////////////////
    // biquad cascade

    for (genvar n = 0; n < NUM_BANDS; n++) begin : g_band
        eq_band u_band (
            .clk          (clk),
            .reset_n      (reset_n),
            .coeff_shift  (coeff_shift),
            .coeff_word   (coeff_word[n]),
            .coeff_commit (coeff_commit),
            .in_valid     (band_valid[n]),
            .in_sample    (band_sample[n]),
            .out_valid    (band_valid[n + 1]),
            .out_sample   (band_sample[n + 1])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // output stage

    effect_output u_effect (
        .clk         (clk),
        .reset_n     (reset_n),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_data    (cfg_data),
        .dry_valid   (in_valid),              // raw input, one cycle path
        .dry_sample  (in_sample),
        .eq_valid    (band_valid[NUM_BANDS]),
        .eq_sample   (band_sample[NUM_BANDS]),
        .out_valid   (out_valid),
        .out_sample  (out_sample)
    );

endmodule

//--- effect_output.sv
module effect_output
    import audio_eq_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       cfg_write,
    input  cfg_addr_t  cfg_addr,
    input  cfg_data_t  cfg_data,
    input  logic       dry_valid,
    input  stereo_t    dry_sample,
    input  logic       eq_valid,
    input  stereo_t    eq_sample,
    output logic       out_valid,
    output stereo_t    out_sample
);

    logic        limit_en;                    // bit of the first enable word
    logic        eq_en;                       // bit of the second enable word
    logic [15:0] limit;                       // clip magnitude

    logic        src_valid;
    stereo_t     dry_clipped;

    // clip one channel to +/- limit, compared with one extra bit of headroom
    function automatic sample_t clip(input sample_t x, input logic [15:0] mag);
        logic signed [16:0] hi;
        logic signed [16:0] lo;
        hi = $signed({1'b0, mag});
        lo = -hi;
        if ($signed({x[15], x}) > hi) begin
            return sample_t'(hi);
        end else if ($signed({x[15], x}) < lo) begin
            return sample_t'(lo);
        end
        return x;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // effect registers

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            limit_en <= 1'b0;
            eq_en    <= 1'b0;
            limit    <= '0;
        end else if (cfg_write) begin
            case (cfg_addr)
                LIMIT_ADDR:      limit    <= cfg_data[15:0];
                EFFECT_EN1_ADDR: limit_en <= cfg_data[LIMIT_EN_BIT];
                EFFECT_EN2_ADDR: eq_en    <= cfg_data[EQ_EN_BIT];
                default: ;                    // other addresses belong to the loader
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output select, eq over limiter over dry

    assign dry_clipped = {clip(sample_t'(dry_sample[31:16]), limit),
                          clip(sample_t'(dry_sample[15:0]), limit)};

    assign src_valid = eq_en ? eq_valid : dry_valid;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= src_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (src_valid) begin
            if (eq_en) begin
                out_sample <= eq_sample;
            end else if (limit_en) begin
                out_sample <= dry_clipped;
            end else begin
                out_sample <= dry_sample;
            end
        end
    end

endmodule

//--- eq_band.sv
module eq_band
    import audio_eq_pkg::*;
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     coeff_shift,
    input  coef_t    coeff_word,
    input  logic     coeff_commit,
    input  logic     in_valid,
    input  stereo_t  in_sample,
    output logic     out_valid,
    output stereo_t  out_sample
);

    coef_t   shadow [TAPS_PER_BAND];          // filled by the loader
    coef_t   active [TAPS_PER_BAND];          // used by the filter

    sample_t in_l;
    sample_t in_r;
    sample_t xl1, xl2, yl1, yl2;              // left history
    sample_t xr1, xr2, yr1, yr2;              // right history
    sample_t y_l;
    sample_t y_r;

    // direct form I, taps in the order b0 b1 b2 a1 a2
    function automatic sample_t biquad(input sample_t x, input sample_t x1,
                                       input sample_t x2, input sample_t y1,
                                       input sample_t y2);
        acc_t acc;
        acc = acc_t'(active[0]) * acc_t'(x)
            + acc_t'(active[1]) * acc_t'(x1)
            + acc_t'(active[2]) * acc_t'(x2)
            - acc_t'(active[3]) * acc_t'(y1)
            - acc_t'(active[4]) * acc_t'(y2);
        acc = acc >>> COEF_FRAC;              // floor, not round
        if (acc > acc_t'(SAMPLE_MAX)) begin
            return SAMPLE_MAX;
        end else if (acc < acc_t'(SAMPLE_MIN)) begin
            return SAMPLE_MIN;
        end
        return sample_t'(acc);
    endfunction

    assign in_l = sample_t'(in_sample[31:16]);
    assign in_r = sample_t'(in_sample[15:0]);

    always_comb begin
        y_l = biquad(in_l, xl1, xl2, yl1, yl2);
        y_r = biquad(in_r, xr1, xr2, yr1, yr2);
    end

    ////////////////////////////////////////////////////////////////////////////
    // coefficient sets

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int t = 0; t < TAPS_PER_BAND; t++) begin
                shadow[t] <= '0;
                active[t] <= '0;
            end
        end else begin
            if (coeff_shift) begin            // b0 ends up in slot 0
                for (int t = 0; t < TAPS_PER_BAND - 1; t++) begin
                    shadow[t] <= shadow[t + 1];
                end
                shadow[TAPS_PER_BAND - 1] <= coeff_word;
            end
            if (coeff_commit) begin
                active <= shadow;             // whole set at once
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // filter state

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
            {xl1, xl2, yl1, yl2} <= '0;
            {xr1, xr2, yr1, yr2} <= '0;
        end else begin
            out_valid <= in_valid;
            if (in_valid) begin
                xl2 <= xl1;
                xl1 <= in_l;
                yl2 <= yl1;
                yl1 <= y_l;
                xr2 <= xr1;
                xr1 <= in_r;
                yr2 <= yr1;
                yr1 <= y_r;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_sample <= {y_l, y_r};
        end
    end

endmodule

//--- eq_coeff_loader.sv
module eq_coeff_loader
    import audio_eq_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          cfg_write,
    input  cfg_addr_t     cfg_addr,
    input  cfg_data_t     cfg_data,
    output logic          coeff_shift,
    output coef_t         coeff_word [NUM_BANDS],
    output logic          coeff_commit
);

    coef_t         coef_mem [NUM_BANDS][TAPS_PER_BAND];   // staged taps per band
    loader_state_t state;
    logic [2:0]    tap_cnt;                   // tap being presented in step

    logic          wr_hit;                    // address inside the eq window
    band_idx_t     wr_band;
    logic [2:0]    wr_tap;
    logic          start_load;

    ////////////////////////////////////////////////////////////////////////////
    // address decode

    always_comb begin
        wr_hit  = 1'b0;
        wr_band = '0;
        wr_tap  = '0;
        for (int b = 0; b < NUM_BANDS; b++) begin
            for (int t = 0; t < TAPS_PER_BAND; t++) begin
                if (cfg_addr == cfg_addr_t'(EQ_BASE_ADDR + TAPS_PER_BAND * b + t)) begin
                    wr_hit  = 1'b1;
                    wr_band = band_idx_t'(b);
                    wr_tap  = 3'(t);
                end
            end
        end
    end

    // the last tap of any band kicks off a full reload
    assign start_load = cfg_write && wr_hit && (wr_tap == 3'(TAPS_PER_BAND - 1));

    ////////////////////////////////////////////////////////////////////////////
    // coefficient store

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            for (int b = 0; b < NUM_BANDS; b++) begin
                for (int t = 0; t < TAPS_PER_BAND; t++) begin
                    coef_mem[b][t] <= '0;
                end
            end
        end else if (cfg_write && wr_hit) begin
            coef_mem[wr_band][wr_tap] <= coef_t'(cfg_data);
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // load sequencer

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state   <= IDLE;
            tap_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (start_load) begin   // triggers while busy are dropped
                        state   <= STEP;
                        tap_cnt <= '0;
                    end
                end
                STEP: begin
                    if (tap_cnt == 3'(TAPS_PER_BAND - 1)) begin
                        state <= COMMIT;
                    end else begin
                        tap_cnt <= tap_cnt + 3'd1;
                    end
                end
                COMMIT: state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign coeff_shift  = (state == STEP);
    assign coeff_commit = (state == COMMIT);

    // all bands receive the same tap number in parallel
    always_comb begin
        for (int b = 0; b < NUM_BANDS; b++) begin
            coeff_word[b] = coef_mem[b][tap_cnt];
        end
    end

endmodule

//--- audio_eq_pkg.sv
package audio_eq_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // data widths

    typedef logic signed [15:0] sample_t;     // one channel, two's complement
    typedef logic        [31:0] stereo_t;     // left in [31:16], right in [15:0]
    typedef logic signed [17:0] coef_t;       // q3.14 filter coefficient
    typedef logic        [5:0]  cfg_addr_t;   // register map address
    typedef logic        [17:0] cfg_data_t;   // register map data word
    typedef logic signed [39:0] acc_t;        // biquad sum of products
    typedef logic        [2:0]  band_idx_t;   // equalizer band number

    typedef enum logic [1:0] {
        IDLE,                                 // waiting for a tap-4 write
        STEP,                                 // shifting taps into the bands
        COMMIT                                // shadow to active in all bands
    } loader_state_t;

    ////////////////////////////////////////////////////////////////////////////
    // equalizer geometry

    localparam int NUM_BANDS     = 5;
    localparam int TAPS_PER_BAND = 5;         // b0 b1 b2 a1 a2, a0 is unity
    localparam int COEF_FRAC     = 14;

    ////////////////////////////////////////////////////////////////////////////
    // register map

    // band n, tap k lives at EQ_BASE_ADDR + 5*n + k
    localparam cfg_addr_t EQ_BASE_ADDR    = 6'd15;
    localparam cfg_addr_t LIMIT_ADDR      = 6'd45;   // limiter magnitude
    localparam cfg_addr_t EFFECT_EN1_ADDR = 6'd61;
    localparam cfg_addr_t EFFECT_EN2_ADDR = 6'd62;

    localparam int LIMIT_EN_BIT = 0;          // in the word at 61
    localparam int EQ_EN_BIT    = 4;          // in the word at 62

    ////////////////////////////////////////////////////////////////////////////
    // saturation bounds

    localparam sample_t SAMPLE_MAX = 16'sh7fff;
    localparam sample_t SAMPLE_MIN = 16'sh8000;

endpackage
